// File: run.sh
#!/bin/sh
# builds and runs the store queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_store_queue -f store_queue.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1

// File: sq_cfg_pkg.sv
package sq_cfg_pkg;

    // queue geometry
    localparam int sq_depth = 8;
    localparam int sq_idx_w = 3;

    // index plus one wrap bit
    localparam int sq_ptr_w = 4;

    // datapath
    localparam int data_w = 32;
    localparam int byte_n = 4;

    // byte address and the word address cut from it
    localparam int addr_w = 32;
    localparam int word_addr_w = 30;

endpackage

// File: sq_checker.sv
module sq_checker (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               alloc_i,
    input  logic                               alloc_ready_o,
    input  logic [sq_cfg_pkg::sq_ptr_w-1:0]    alloc_idx_o,
    input  logic                               addr_en_i,
    input  logic [sq_cfg_pkg::sq_idx_w-1:0]    addr_idx_i,
    input  logic [sq_cfg_pkg::addr_w-1:0]      paddr_i,
    input  sq_types_pkg::access_size_e         size_i,
    input  logic                               data_en_i,
    input  logic [sq_cfg_pkg::sq_idx_w-1:0]    data_idx_i,
    input  logic [sq_cfg_pkg::data_w-1:0]      data_i,
    input  logic                               commit_i,
    input  logic                               load_en_i,
    input  logic [sq_cfg_pkg::word_addr_w-1:0] load_addr_i,
    input  logic [sq_cfg_pkg::sq_ptr_w-1:0]    load_idx_i,
    input  logic [sq_cfg_pkg::byte_n-1:0]      fwd_mask_o,
    input  logic [sq_cfg_pkg::data_w-1:0]      fwd_data_o,
    input  logic                               fwd_data_invalid_o,
    input  logic                               wb_cyc_o,
    input  logic                               wb_stb_o,
    input  logic                               wb_we_o,
    input  logic [sq_cfg_pkg::addr_w-1:0]      wb_adr_o,
    input  logic [sq_cfg_pkg::data_w-1:0]      wb_dat_o,
    input  logic [sq_cfg_pkg::byte_n-1:0]      wb_sel_o,
    input  logic                               wb_ack_i,
    input  int                                 test_num,
    input  logic                               test_end,
    input  logic                               run_end,
    output int                                 errors_o
);
    timeunit 1ns;
    timeprecision 1ps;

    string test_names [7] = '{"", "reset and index", "full", "drain order",
                              "no early drain", "forwarding", "missing data"};

    // model of the queue
    bit m_valid [8], m_av [8], m_dv [8], m_cm [8];
    logic [29:0] m_waddr [8];
    logic [3:0] m_mask [8];
    logic [31:0] m_data [8];
    sq_types_pkg::access_size_e m_size [8];
    logic [3:0] m_head, m_tail, m_cmt;

    bit exp_load, after_rst, ended;
    logic [3:0] exp_mask, exp_pend;
    logic [31:0] exp_data;
    int checks, errors, test_errs;

    assign errors_o = errors;

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            test_errs++;
            $display("** Error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        test_errs++;
        $display("failure: %s", msg);
    endtask

    function automatic logic [31:0] lanes_of(input logic [31:0] d, input logic [3:0] m);
        logic [31:0] r;
        for (int i = 0; i < 4; i++) r[i*8 +: 8] = m[i] ? d[i*8 +: 8] : 8'h00;
        return r;
    endfunction

    // bytes touched by a store of the given size at the given offset
    function automatic logic [3:0] size_mask(input sq_types_pkg::access_size_e sz,
                                             input logic [1:0] off);
        int n;
        int first;
        logic [3:0] m;
        case (sz)
            sq_types_pkg::SIZE_BYTE: n = 1;
            sq_types_pkg::SIZE_HALF: n = 2;
            default:                 n = 4;
        endcase
        first = (n == 4) ? 0 : int'(off);
        for (int i = 0; i < 4; i++) begin
            m[i] = (i >= first) && (i < first + n);
        end
        return m;
    endfunction

    // low bytes of the store repeated over every lane
    function automatic logic [31:0] size_data(input sq_types_pkg::access_size_e sz,
                                              input logic [31:0] d);
        int n;
        logic [31:0] r;
        case (sz)
            sq_types_pkg::SIZE_BYTE: n = 1;
            sq_types_pkg::SIZE_HALF: n = 2;
            default:                 n = 4;
        endcase
        for (int i = 0; i < 4; i++) begin
            r[i*8 +: 8] = d[(i % n)*8 +: 8];
        end
        return r;
    endfunction

    always @(negedge clk) begin : monitor
        logic [2:0] h;
        logic [2:0] s;
        logic [3:0] p;
        bit full;
        if (rst) begin
            m_head = '0;
            m_tail = '0;
            m_cmt  = '0;
            foreach (m_valid[i]) m_valid[i] = 1'b0;
            exp_load  = 1'b0;
            after_rst = 1'b1;
        end else begin
            if (after_rst) begin
                compare_value("alloc_ready_o", 1, alloc_ready_o);
                compare_value("wb_cyc_o", 0, wb_cyc_o);
                compare_value("wb_stb_o", 0, wb_stb_o);
                after_rst = 1'b0;
            end
            if (exp_load) begin
                compare_value("fwd_mask_o", exp_mask, fwd_mask_o);
                compare_value("fwd_data_o", lanes_of(exp_data, exp_mask & ~exp_pend),
                              lanes_of(fwd_data_o, exp_mask & ~exp_pend));
                compare_value("fwd_data_invalid_o", |exp_pend, fwd_data_invalid_o);
            end else begin
                compare_value("fwd_mask_o", 0, fwd_mask_o);
                compare_value("fwd_data_o", 0, fwd_data_o);
                compare_value("fwd_data_invalid_o", 0, fwd_data_invalid_o);
            end
            full = (m_tail - m_head) == 4'd8;
            compare_value("alloc_ready_o", !full, alloc_ready_o);
            compare_value("alloc_idx_o", m_tail, alloc_idx_o);
            h = m_head[2:0];
            if (wb_cyc_o) begin
                if (!(m_valid[h] && m_av[h] && m_dv[h] && m_cm[h]))
                    report_failure("bus write for a head entry not complete and committed");
                compare_value("wb_stb_o", 1, wb_stb_o);
                compare_value("wb_we_o", 1, wb_we_o);
                if (wb_ack_i) begin
                    compare_value("wb_adr_o", {m_waddr[h], 2'b00}, wb_adr_o);
                    compare_value("wb_dat_o", m_data[h], wb_dat_o);
                    compare_value("wb_sel_o", m_mask[h], wb_sel_o);
                end
            end else begin
                compare_value("wb_stb_o", 0, wb_stb_o);
            end
            // expected forward result where later older stores overwrite earlier ones
            exp_load = load_en_i;
            exp_mask = '0;
            exp_pend = '0;
            exp_data = '0;
            p = m_head;
            while (load_en_i && p != load_idx_i && p != m_tail) begin
                s = p[2:0];
                if (m_valid[s] && m_av[s] && m_waddr[s] == load_addr_i) begin
                    for (int i = 0; i < 4; i++) begin
                        if (m_mask[s][i]) begin
                            exp_mask[i] = 1'b1;
                            exp_pend[i] = !m_dv[s];
                            exp_data[i*8 +: 8] = m_data[s][i*8 +: 8];
                        end
                    end
                end
                p++;
            end
            // updates that land on the next edge
            if (wb_cyc_o && wb_ack_i) begin
                m_valid[h] = 1'b0;
                m_head++;
            end
            if (alloc_i && !full) begin
                s = m_tail[2:0];
                {m_valid[s], m_av[s], m_dv[s], m_cm[s]} = 4'b1000;
                m_tail++;
            end
            if (addr_en_i) begin
                m_av[addr_idx_i]    = 1'b1;
                m_waddr[addr_idx_i] = paddr_i[31:2];
                m_size[addr_idx_i]  = size_i;
                m_mask[addr_idx_i]  = size_mask(size_i, paddr_i[1:0]);
            end
            if (data_en_i) begin
                m_dv[data_idx_i]   = 1'b1;
                m_data[data_idx_i] = size_data(m_size[data_idx_i], data_i);
            end
            if (commit_i) begin
                m_cm[m_cmt[2:0]] = 1'b1;
                m_cmt++;
            end
            if (test_end) begin
                $display("test %0d %s: %s, %0d errors", test_num, test_names[test_num],
                         (test_errs == 0) ? "ok" : "failed", test_errs);
                test_errs = 0;
            end
            if (run_end && !ended) begin
                $display("checks: %0d, errors: %0d", checks, errors);
                ended = 1'b1;
            end
        end
    end

endmodule

// File: sq_entry_if.sv
interface sq_entry_if;

    // per-entry flags
    logic [sq_cfg_pkg::sq_depth-1:0] valid;
    logic [sq_cfg_pkg::sq_depth-1:0] addr_valid;
    logic [sq_cfg_pkg::sq_depth-1:0] data_valid;
    logic [sq_cfg_pkg::sq_depth-1:0] committed;

    // per-entry payload
    logic [sq_cfg_pkg::word_addr_w-1:0] word_addr [sq_cfg_pkg::sq_depth];
    logic [sq_cfg_pkg::byte_n-1:0]      mask [sq_cfg_pkg::sq_depth];
    logic [sq_cfg_pkg::data_w-1:0]      data [sq_cfg_pkg::sq_depth];

    // pointers with wrap bit
    logic [sq_cfg_pkg::sq_ptr_w-1:0] head;
    logic [sq_cfg_pkg::sq_ptr_w-1:0] tail;

    // head entry written to memory
    logic drain_done;

    modport storage (
        output valid, addr_valid, data_valid, committed,
        output word_addr, mask, data, head, tail,
        input  drain_done
    );

    modport forward (
        input valid, addr_valid, data_valid,
        input word_addr, mask, data, head, tail
    );

    modport drain (
        input  valid, addr_valid, data_valid, committed,
        input  word_addr, mask, data, head,
        output drain_done
    );

endinterface

// File: sq_types_pkg.sv
package sq_types_pkg;

    // store access size, as carried with the address write
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } access_size_e;

    // drain to memory
    typedef enum logic {
        DRAIN_IDLE = 1'b0,
        DRAIN_BUS  = 1'b1
    } drain_state_e;

endpackage

// File: store_data_align.sv
module store_data_align (
    input  sq_types_pkg::access_size_e     size_i,
    input  logic [1:0]                     byte_off_i,
    input  logic [sq_cfg_pkg::data_w-1:0]  data_i,
    output logic [sq_cfg_pkg::byte_n-1:0]  mask_o,
    output logic [sq_cfg_pkg::data_w-1:0]  data_o
);

    always_comb begin
        case (size_i)
            sq_types_pkg::SIZE_BYTE: begin
                mask_o = 4'b0001 << byte_off_i;
            end
            sq_types_pkg::SIZE_HALF: begin
                // odd offset is misaligned
                if (byte_off_i[0]) begin
                    mask_o = '0;
                end else begin
                    mask_o = 4'b0011 << byte_off_i;
                end
            end
            sq_types_pkg::SIZE_WORD: begin
                mask_o = '1;
            end
            default: begin
                mask_o = '0;
            end
        endcase
    end

    // low byte or half copied into every lane
    always_comb begin
        case (size_i)
            sq_types_pkg::SIZE_BYTE: data_o = {sq_cfg_pkg::byte_n{data_i[7:0]}};
            sq_types_pkg::SIZE_HALF: data_o = {(sq_cfg_pkg::byte_n / 2){data_i[15:0]}};
            sq_types_pkg::SIZE_WORD: data_o = data_i;
            default:                 data_o = '0;
        endcase
    end

endmodule

// File: store_drain_wb.sv
module store_drain_wb (
    input  logic                            clk,
    input  logic                            rst,
    sq_entry_if.drain                       sq,
    output logic                            wb_cyc_o,
    output logic                            wb_stb_o,
    output logic                            wb_we_o,
    output logic [sq_cfg_pkg::addr_w-1:0]   wb_adr_o,
    output logic [sq_cfg_pkg::data_w-1:0]   wb_dat_o,
    output logic [sq_cfg_pkg::byte_n-1:0]   wb_sel_o,
    input  logic                            wb_ack_i
);

    sq_types_pkg::drain_state_e state_q;

    logic [sq_cfg_pkg::sq_idx_w-1:0] head_idx;
    logic                            head_ready;

    assign head_idx   = sq.head[sq_cfg_pkg::sq_idx_w-1:0];
    assign head_ready = sq.valid[head_idx] & sq.addr_valid[head_idx] &
                        sq.data_valid[head_idx] & sq.committed[head_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= sq_types_pkg::DRAIN_IDLE;
        end else begin
            case (state_q)
                sq_types_pkg::DRAIN_IDLE: begin
                    if (head_ready) begin
                        state_q <= sq_types_pkg::DRAIN_BUS;
                    end
                end
                sq_types_pkg::DRAIN_BUS: begin
                    if (wb_ack_i) begin
                        state_q <= sq_types_pkg::DRAIN_IDLE;
                    end
                end
                default: state_q <= sq_types_pkg::DRAIN_IDLE;
            endcase
        end
    end

    // bus payload captured from the head entry
    always_ff @(posedge clk) begin
        if (state_q == sq_types_pkg::DRAIN_IDLE && head_ready) begin
            wb_adr_o <= {sq.word_addr[head_idx], 2'b00};
            wb_dat_o <= sq.data[head_idx];
            wb_sel_o <= sq.mask[head_idx];
        end
    end

    assign wb_cyc_o = (state_q == sq_types_pkg::DRAIN_BUS);
    assign wb_stb_o = wb_cyc_o;
    assign wb_we_o  = wb_cyc_o;

    assign sq.drain_done = wb_cyc_o & wb_ack_i;

    a_wb_hold: assert property (@(posedge clk) disable iff (rst)
        wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o) &&
                                   $stable(wb_dat_o) && $stable(wb_sel_o));

endmodule

// File: store_forward_select.sv
module store_forward_select (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                load_en_i,
    input  logic [sq_cfg_pkg::word_addr_w-1:0]  load_addr_i,
    input  logic [sq_cfg_pkg::sq_ptr_w-1:0]     load_idx_i,
    sq_entry_if.forward                         sq,
    output logic [sq_cfg_pkg::byte_n-1:0]       fwd_mask_o,
    output logic [sq_cfg_pkg::data_w-1:0]       fwd_data_o,
    output logic                                fwd_data_invalid_o
);

    logic [sq_cfg_pkg::byte_n-1:0] sel_mask;
    logic [sq_cfg_pkg::byte_n-1:0] sel_pending;
    logic [sq_cfg_pkg::data_w-1:0] sel_data;

    // walk from head towards the load, later hits are younger and win
    always_comb begin
        logic [sq_cfg_pkg::sq_ptr_w-1:0] dist_load;
        logic [sq_cfg_pkg::sq_ptr_w-1:0] dist_tail;
        logic [sq_cfg_pkg::sq_ptr_w-1:0] limit;
        logic [sq_cfg_pkg::sq_ptr_w-1:0] pos;
        logic [sq_cfg_pkg::sq_idx_w-1:0] e;
        logic                            hit;

        dist_load = load_idx_i - sq.head;
        dist_tail = sq.tail - sq.head;
        limit     = (dist_load > dist_tail) ? dist_tail : dist_load;

        sel_mask    = '0;
        sel_pending = '0;
        sel_data    = '0;

        for (int k = 0; k < sq_cfg_pkg::sq_depth; k++) begin
            pos = sq.head + k[sq_cfg_pkg::sq_ptr_w-1:0];
            e   = pos[sq_cfg_pkg::sq_idx_w-1:0];
            hit = (k < limit) && sq.valid[e] && sq.addr_valid[e] &&
                  (sq.word_addr[e] == load_addr_i);
            for (int b = 0; b < sq_cfg_pkg::byte_n; b++) begin
                if (hit && sq.mask[e][b]) begin
                    sel_mask[b]          = 1'b1;
                    sel_pending[b]       = ~sq.data_valid[e];
                    sel_data[b*8 +: 8]   = sq.data[e][b*8 +: 8];
                end
            end
        end
    end

    // zero when no load was presented
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fwd_mask_o         <= '0;
            fwd_data_o         <= '0;
            fwd_data_invalid_o <= 1'b0;
        end else if (load_en_i) begin
            fwd_mask_o         <= sel_mask;
            fwd_data_o         <= sel_data;
            fwd_data_invalid_o <= |(sel_mask & sel_pending);
        end else begin
            fwd_mask_o         <= '0;
            fwd_data_o         <= '0;
            fwd_data_invalid_o <= 1'b0;
        end
    end

endmodule

// File: store_queue.f
sq_cfg_pkg.sv
sq_types_pkg.sv
sq_entry_if.sv
store_data_align.sv
store_queue_entries.sv
store_forward_select.sv
store_drain_wb.sv
store_queue.sv
sq_checker.sv
tb_store_queue.sv

// File: store_queue.sv
module store_queue (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                alloc_i,
    output logic                                alloc_ready_o,
    output logic [sq_cfg_pkg::sq_ptr_w-1:0]     alloc_idx_o,
    input  logic                                addr_en_i,
    input  logic [sq_cfg_pkg::sq_idx_w-1:0]     addr_idx_i,
    input  logic [sq_cfg_pkg::addr_w-1:0]       paddr_i,
    input  sq_types_pkg::access_size_e          size_i,
    input  logic                                data_en_i,
    input  logic [sq_cfg_pkg::sq_idx_w-1:0]     data_idx_i,
    input  logic [sq_cfg_pkg::data_w-1:0]       data_i,
    input  logic                                commit_i,
    input  logic                                load_en_i,
    input  logic [sq_cfg_pkg::word_addr_w-1:0]  load_addr_i,
    input  logic [sq_cfg_pkg::sq_ptr_w-1:0]     load_idx_i,
    output logic [sq_cfg_pkg::byte_n-1:0]       fwd_mask_o,
    output logic [sq_cfg_pkg::data_w-1:0]       fwd_data_o,
    output logic                                fwd_data_invalid_o,
    output logic                                wb_cyc_o,
    output logic                                wb_stb_o,
    output logic                                wb_we_o,
    output logic [sq_cfg_pkg::addr_w-1:0]       wb_adr_o,
    output logic [sq_cfg_pkg::data_w-1:0]       wb_dat_o,
    output logic [sq_cfg_pkg::byte_n-1:0]       wb_sel_o,
    input  logic                                wb_ack_i
);

    logic [sq_cfg_pkg::word_addr_w-1:0] word_addr;
    logic [1:0]                         byte_off;
    logic [sq_cfg_pkg::byte_n-1:0]      addr_mask;
    logic [sq_cfg_pkg::data_w-1:0]      data_word;
    sq_types_pkg::access_size_e         entry_size;

    sq_entry_if sq_if ();

    assign word_addr = paddr_i[sq_cfg_pkg::addr_w-1:2];
    assign byte_off  = paddr_i[1:0];

    // address write side, mask only
    store_data_align mask_align_i (
        .size_i     (size_i),
        .byte_off_i (byte_off),
        .data_i     ('0),
        .mask_o     (addr_mask),
        .data_o     ()
    );

    // data write side, lanes replicated by the entry's size
    store_data_align data_align_i (
        .size_i     (entry_size),
        .byte_off_i (2'b00),
        .data_i     (data_i),
        .mask_o     (),
        .data_o     (data_word)
    );

    store_queue_entries entries_i (
        .clk           (clk),
        .rst           (rst),
        .alloc_i       (alloc_i),
        .alloc_ready_o (alloc_ready_o),
        .alloc_idx_o   (alloc_idx_o),
        .addr_en_i     (addr_en_i),
        .addr_idx_i    (addr_idx_i),
        .word_addr_i   (word_addr),
        .mask_i        (addr_mask),
        .size_i        (size_i),
        .data_idx_i    (data_idx_i),
        .entry_size_o  (entry_size),
        .data_en_i     (data_en_i),
        .data_word_i   (data_word),
        .commit_i      (commit_i),
        .sq            (sq_if.storage)
    );

    store_forward_select forward_i (
        .clk                (clk),
        .rst                (rst),
        .load_en_i          (load_en_i),
        .load_addr_i        (load_addr_i),
        .load_idx_i         (load_idx_i),
        .sq                 (sq_if.forward),
        .fwd_mask_o         (fwd_mask_o),
        .fwd_data_o         (fwd_data_o),
        .fwd_data_invalid_o (fwd_data_invalid_o)
    );

    store_drain_wb drain_i (
        .clk      (clk),
        .rst      (rst),
        .sq       (sq_if.drain),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o),
        .wb_sel_o (wb_sel_o),
        .wb_ack_i (wb_ack_i)
    );

endmodule

// File: store_queue_entries.sv
module store_queue_entries (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                alloc_i,
    output logic                                alloc_ready_o,
    output logic [sq_cfg_pkg::sq_ptr_w-1:0]     alloc_idx_o,
    input  logic                                addr_en_i,
    input  logic [sq_cfg_pkg::sq_idx_w-1:0]     addr_idx_i,
    input  logic [sq_cfg_pkg::word_addr_w-1:0]  word_addr_i,
    input  logic [sq_cfg_pkg::byte_n-1:0]       mask_i,
    input  sq_types_pkg::access_size_e          size_i,
    input  logic [sq_cfg_pkg::sq_idx_w-1:0]     data_idx_i,
    output sq_types_pkg::access_size_e          entry_size_o,
    input  logic                                data_en_i,
    input  logic [sq_cfg_pkg::data_w-1:0]       data_word_i,
    input  logic                                commit_i,
    sq_entry_if.storage                         sq
);

    logic [sq_cfg_pkg::sq_ptr_w-1:0] head_q;
    logic [sq_cfg_pkg::sq_ptr_w-1:0] tail_q;
    logic [sq_cfg_pkg::sq_ptr_w-1:0] cmt_q;
    logic [sq_cfg_pkg::sq_ptr_w-1:0] used_cnt;
    logic [sq_cfg_pkg::sq_ptr_w-1:0] cmt_cnt;
    logic                            full;
    logic                            alloc_fire;
    logic                            addr_same;

    sq_types_pkg::access_size_e size_q [sq_cfg_pkg::sq_depth];

    // same index on a different lap
    assign full = (tail_q[sq_cfg_pkg::sq_idx_w-1:0] == head_q[sq_cfg_pkg::sq_idx_w-1:0]) &&
                  (tail_q[sq_cfg_pkg::sq_ptr_w-1] != head_q[sq_cfg_pkg::sq_ptr_w-1]);

    assign alloc_ready_o = ~full;
    assign alloc_fire    = alloc_i & ~full;
    assign alloc_idx_o   = tail_q;

    assign sq.head = head_q;
    assign sq.tail = tail_q;

    assign used_cnt = tail_q - head_q;
    assign cmt_cnt  = cmt_q - head_q;

    // data write size with a bypass from a same-cycle address write
    assign addr_same    = addr_en_i && (addr_idx_i == data_idx_i);
    assign entry_size_o = addr_same ? size_i : size_q[data_idx_i];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
            cmt_q  <= '0;
        end else begin
            if (alloc_fire) begin
                tail_q <= tail_q + 1'b1;
            end
            if (commit_i) begin
                cmt_q <= cmt_q + 1'b1;
            end
            if (sq.drain_done) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sq.valid      <= '0;
            sq.addr_valid <= '0;
            sq.data_valid <= '0;
            sq.committed  <= '0;
        end else begin
            if (sq.drain_done) begin
                sq.valid[head_q[sq_cfg_pkg::sq_idx_w-1:0]] <= 1'b0;
            end
            if (alloc_fire) begin
                sq.valid[tail_q[sq_cfg_pkg::sq_idx_w-1:0]]      <= 1'b1;
                sq.addr_valid[tail_q[sq_cfg_pkg::sq_idx_w-1:0]] <= 1'b0;
                sq.data_valid[tail_q[sq_cfg_pkg::sq_idx_w-1:0]] <= 1'b0;
                sq.committed[tail_q[sq_cfg_pkg::sq_idx_w-1:0]]  <= 1'b0;
            end
            if (addr_en_i) begin
                sq.addr_valid[addr_idx_i] <= 1'b1;
            end
            if (data_en_i) begin
                sq.data_valid[data_idx_i] <= 1'b1;
            end
            if (commit_i) begin
                sq.committed[cmt_q[sq_cfg_pkg::sq_idx_w-1:0]] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (addr_en_i) begin
            sq.word_addr[addr_idx_i] <= word_addr_i;
            sq.mask[addr_idx_i]      <= mask_i;
            size_q[addr_idx_i]       <= size_i;
        end
        if (data_en_i) begin
            sq.data[data_idx_i] <= data_word_i;
        end
    end

    // an allocation never lands on a live entry
    a_alloc_free_slot: assert property (@(posedge clk) disable iff (rst)
        alloc_fire |-> !sq.valid[tail_q[sq_cfg_pkg::sq_idx_w-1:0]]);

    a_commit_in_range: assert property (@(posedge clk) disable iff (rst)
        commit_i |-> cmt_cnt < used_cnt);

    a_addr_to_valid: assert property (@(posedge clk) disable iff (rst)
        addr_en_i |-> sq.valid[addr_idx_i]);

    // data lanes follow the stored size so the address write comes first
    a_data_to_valid: assert property (@(posedge clk) disable iff (rst)
        data_en_i |-> sq.valid[data_idx_i] && (sq.addr_valid[data_idx_i] || addr_same));

endmodule

// File: tb_store_queue.sv
module tb_store_queue;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_tests = 6;

    logic clk;
    logic rst;
    logic alloc_i, alloc_ready_o;
    logic [sq_cfg_pkg::sq_ptr_w-1:0] alloc_idx_o;
    logic addr_en_i;
    logic [sq_cfg_pkg::sq_idx_w-1:0] addr_idx_i;
    logic [sq_cfg_pkg::addr_w-1:0] paddr_i;
    sq_types_pkg::access_size_e size_i;
    logic data_en_i;
    logic [sq_cfg_pkg::sq_idx_w-1:0] data_idx_i;
    logic [sq_cfg_pkg::data_w-1:0] data_i;
    logic commit_i, load_en_i;
    logic [sq_cfg_pkg::word_addr_w-1:0] load_addr_i;
    logic [sq_cfg_pkg::sq_ptr_w-1:0] load_idx_i;
    logic [sq_cfg_pkg::byte_n-1:0] fwd_mask_o, wb_sel_o;
    logic [sq_cfg_pkg::data_w-1:0] fwd_data_o, wb_dat_o;
    logic fwd_data_invalid_o, wb_cyc_o, wb_stb_o, wb_we_o;
    logic wb_ack_i = 1'b0;
    logic [sq_cfg_pkg::addr_w-1:0] wb_adr_o;

    int test_num;
    logic test_end, run_end;
    int check_errors;
    int tb_fail;

    // stimulus bookkeeping in allocation order
    int alloc_cnt, commit_cnt, drain_cnt, held_ptr, ack_wait;
    bit has_addr [sq_cfg_pkg::sq_depth];
    bit has_data [sq_cfg_pkg::sq_depth];
    bit ack_en, hold_data;

    store_queue dut_i (.*);

    sq_checker checker_i (.*, .errors_o(check_errors));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // wishbone slave acking after 0 to 5 idle cycles
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack_i  <= 1'b0;
            ack_wait  <= 0;
            drain_cnt <= 0;
        end else if (wb_ack_i) begin
            wb_ack_i  <= 1'b0;
            drain_cnt <= drain_cnt + 1;
        end else if (wb_cyc_o && ack_en) begin
            if (ack_wait == 0) begin
                wb_ack_i <= 1'b1;
                ack_wait <= $urandom_range(0, 5);
            end else begin
                ack_wait <= ack_wait - 1;
            end
        end
    end

    task automatic step(input int pa, input int pad, input int pd, input int pc,
                        input int pl);
        int cand[$];
        int k;
        int sz;
        int off;
        @(posedge clk);
        if (alloc_i && alloc_ready_o) begin
            has_addr[alloc_cnt % 8] = 1'b0;
            has_data[alloc_cnt % 8] = 1'b0;
            alloc_cnt++;
        end
        alloc_i   <= ($urandom_range(0, 99) < pa);
        addr_en_i <= 1'b0;
        data_en_i <= 1'b0;
        commit_i  <= 1'b0;
        for (int p = drain_cnt; p < alloc_cnt; p++) begin
            if (!has_addr[p % 8]) cand.push_back(p);
        end
        if (cand.size() > 0 && $urandom_range(0, 99) < pad) begin
            k   = cand[$urandom_range(0, cand.size() - 1)];
            sz  = $urandom_range(0, 2);
            off = (sz == 0) ? $urandom_range(0, 3) : (sz == 1) ? 2 * $urandom_range(0, 1) : 0;
            has_addr[k % 8] = 1'b1;
            addr_en_i  <= 1'b1;
            addr_idx_i <= 3'(k);
            size_i     <= sq_types_pkg::access_size_e'(sz);
            paddr_i    <= {30'(32'h40 + $urandom_range(0, 3)), 2'(off)};
        end
        cand = {};
        for (int p = drain_cnt; p < alloc_cnt; p++) begin
            if (has_addr[p % 8] && !has_data[p % 8] && !(hold_data && p == held_ptr))
                cand.push_back(p);
        end
        if (cand.size() > 0 && $urandom_range(0, 99) < pd) begin
            k = cand[$urandom_range(0, cand.size() - 1)];
            has_data[k % 8] = 1'b1;
            data_en_i  <= 1'b1;
            data_idx_i <= 3'(k);
            data_i     <= $urandom;
        end
        if (commit_cnt < alloc_cnt && $urandom_range(0, 99) < pc) begin
            commit_i <= 1'b1;
            commit_cnt++;
        end
        load_en_i   <= ($urandom_range(0, 99) < pl);
        load_addr_i <= 30'(32'h40 + $urandom_range(0, 3));
        load_idx_i  <= 4'(alloc_cnt - int'($urandom_range(0, alloc_cnt - drain_cnt)));
    endtask

    // finish every outstanding store and let it drain
    task automatic settle();
        do begin
            step(0, 100, 100, 100, 0);
        end while (drain_cnt < alloc_cnt || alloc_i);
    endtask

    task automatic close_test();
        @(posedge clk);
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
        test_num <= test_num + 1;
    endtask

    initial begin
        int n;
        void'($urandom(32'ha95b5bba));
        rst = 1'b1;
        {alloc_i, addr_en_i, data_en_i, commit_i, load_en_i} = '0;
        addr_idx_i = '0;
        paddr_i = '0;
        size_i = sq_types_pkg::SIZE_WORD;
        data_idx_i = '0;
        data_i = '0;
        load_addr_i = '0;
        load_idx_i = '0;
        {test_end, run_end, ack_en, hold_data} = '0;
        {alloc_cnt, commit_cnt, held_ptr, tb_fail} = '0;
        test_num = 1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        ack_en <= 1'b1;

        repeat (40) step(60, 50, 50, 40, 30);
        settle();
        close_test();

        // back-pressure until the queue fills
        ack_en <= 1'b0;
        n = 0;
        repeat (30) step(100, 100, 100, 100, 0);
        while (alloc_ready_o && n < 50) begin
            step(100, 100, 100, 100, 0);
            n++;
        end
        if (alloc_ready_o) begin
            $display("full test: alloc_ready_o never went low with ack withheld");
            tb_fail++;
        end
        ack_en <= 1'b1;
        settle();
        close_test();

        repeat (300) step(40, 40, 40, 40, 20);
        settle();
        close_test();

        // head entry keeps its data back so nothing may drain
        hold_data = 1'b1;
        held_ptr  = alloc_cnt;
        repeat (60) step(50, 80, 80, 80, 0);
        hold_data = 1'b0;
        settle();
        close_test();

        repeat (400) step(40, 50, 50, 40, 100);
        settle();
        close_test();

        repeat (300) step(40, 60, 10, 40, 100);
        settle();
        close_test();

        run_end <= 1'b1;
        @(negedge clk);
        @(posedge clk);
        if (check_errors == 0 && tb_fail == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(num_tests * 2000 * 10);
        $display("timeout: run did not complete within %0d cycles", num_tests * 2000);
        $display("Simulation FAILED");
        $finish;
    end

endmodule
